//--- noc_pkg.sv
package noc_pkg;

	localparam int ADDR_W = 4;
	localparam int SEQ_W = 4;
	localparam int VALUE_W = 8;

	// Number of cores the address field can reach
	localparam int MAX_CORES = 2 ** ADDR_W;

	typedef logic [ADDR_W-1:0] core_addr_t;
	typedef logic [SEQ_W-1:0] seq_t;  // Wraps from 15 to 0
	typedef logic [VALUE_W-1:0] sensor_value_t;

	typedef struct packed {
		core_addr_t addr;  // Sent in the high byte with seq
		seq_t seq;
		sensor_value_t value;  // Sent alone in the low byte
	} flit_t;

	// Entry i holds the sensor input of core i
	typedef sensor_value_t [MAX_CORES-1:0] sensor_bank_t;

endpackage

//--- uart_pkg.sv
package uart_pkg;

	localparam int DATA_BITS = 8;

	// Line levels of the framing bits
	localparam logic START_BIT = 1'b0;
	localparam logic STOP_BIT = 1'b1;  // Also the idle level

	typedef enum logic [1:0] {
		IDLE,
		START,
		DATA,
		STOP
	} tx_state_t;

endpackage

//--- sensor_sampler.sv
module sensor_sampler #(
	parameter int NUM_CORES = 8
) (
	input  logic clk,
	input  logic rst_n,
	input  logic sample_trigger,
	input  logic [NUM_CORES-1:0] sample_enable,
	input  noc_pkg::sensor_bank_t sensor_values,
	output logic [NUM_CORES-1:0] capture,
	output noc_pkg::sensor_bank_t capture_value
);
	import noc_pkg::*;

	sensor_value_t snap_q [NUM_CORES];

	// Enabled cores see the strobe one cycle after the trigger
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			capture <= '0;
		end else begin
			capture <= sample_trigger ? sample_enable : '0;
		end
	end

	always_ff @(posedge clk) begin
		if (sample_trigger) begin
			for (int i = 0; i < NUM_CORES; i++) begin
				snap_q[i] <= sensor_values[i];  // One snapshot shared by all cores
			end
		end
	end

	always_comb begin
		capture_value = '0;  // Entries above NUM_CORES read as zero
		for (int i = 0; i < NUM_CORES; i++) begin
			capture_value[i] = snap_q[i];
		end
	end

endmodule

//--- sensor_ni.sv
module sensor_ni #(
	parameter noc_pkg::core_addr_t CORE_ADDR = '0
) (
	input  logic clk,
	input  logic rst_n,
	input  logic capture,
	input  noc_pkg::sensor_value_t value,
	output logic req,
	output noc_pkg::flit_t flit,
	input  logic taken
);
	import noc_pkg::*;

	seq_t seq_q;
	logic load;

	// A capture is dropped while the previous flit still waits
	assign load = capture && !req;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req <= 1'b0;
			seq_q <= '0;
		end else begin
			if (taken) begin
				req <= 1'b0;
				seq_q <= seq_q + seq_t'(1);  // Wraps naturally at 4 bits
			end else if (load) begin
				req <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			flit <= '{addr: CORE_ADDR, seq: seq_q, value: value};
		end
	end

endmodule

//--- flit_arbiter.sv
module flit_arbiter #(
	parameter int NUM_CORES = 8
) (
	input  logic clk,
	input  logic rst_n,
	input  logic [NUM_CORES-1:0] req,
	input  noc_pkg::flit_t flits [NUM_CORES],
	output logic [NUM_CORES-1:0] taken,
	output logic [uart_pkg::DATA_BITS-1:0] tx_byte,
	output logic tx_start,
	input  logic bussy
);
	import noc_pkg::*;

	localparam int IDX_W = $clog2(NUM_CORES);

	typedef enum logic [1:0] {
		EMPTY,
		HIGH_BYTE,
		LOW_BYTE
	} phase_t;

	phase_t phase_q;
	logic [IDX_W-1:0] last_q;
	logic [IDX_W-1:0] grant_idx;
	logic grant_valid;
	logic can_send;
	flit_t hold_q;

	// Search starts just after the last served core and wraps around
	always_comb begin
		int cand;
		grant_valid = 1'b0;
		grant_idx = last_q;
		for (int off = 1; off <= NUM_CORES; off++) begin
			cand = int'(last_q) + off;
			if (cand >= NUM_CORES) begin
				cand = cand - NUM_CORES;
			end
			if (!grant_valid && req[cand]) begin
				grant_valid = 1'b1;
				grant_idx = IDX_W'(cand);
			end
		end
	end

	always_comb begin
		taken = '0;
		if (phase_q == EMPTY && grant_valid) begin
			taken[grant_idx] = 1'b1;
		end
	end

	// The UART raises bussy only one edge after tx_start
	assign can_send = !bussy && !tx_start;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			phase_q <= EMPTY;
			last_q <= IDX_W'(NUM_CORES - 1);  // Core 0 goes first
			tx_start <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			case (phase_q)
				EMPTY: begin
					if (grant_valid) begin
						phase_q <= HIGH_BYTE;
						last_q <= grant_idx;
					end
				end
				HIGH_BYTE: begin
					if (can_send) begin
						tx_start <= 1'b1;
						phase_q <= LOW_BYTE;
					end
				end
				LOW_BYTE: begin
					if (can_send) begin
						tx_start <= 1'b1;
						phase_q <= EMPTY;
					end
				end
				default: phase_q <= EMPTY;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (phase_q == EMPTY && grant_valid) begin
			hold_q <= flits[grant_idx];
		end
		if (can_send && phase_q == HIGH_BYTE) begin
			tx_byte <= {hold_q.addr, hold_q.seq};
		end else if (can_send && phase_q == LOW_BYTE) begin
			tx_byte <= hold_q.value;
		end
	end

endmodule

//--- uart_tx.sv
module uart_tx #(
	parameter int CLKS_PER_BIT = 434
) (
	input  logic clk,
	input  logic rst_n,
	input  logic [uart_pkg::DATA_BITS-1:0] tx_byte,
	input  logic tx_start,
	output logic bussy,
	output logic txd
);
	import uart_pkg::*;

	localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
	localparam int BIT_W = $clog2(DATA_BITS);

	tx_state_t state_q;
	logic [CNT_W-1:0] clk_cnt;
	logic [BIT_W-1:0] bit_idx;
	logic [DATA_BITS-1:0] shift_q;
	logic bit_done;

	assign bit_done = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			bussy <= 1'b0;
			txd <= STOP_BIT;
		end else begin
			if (state_q == IDLE || bit_done) begin
				clk_cnt <= '0;
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
			case (state_q)
				IDLE: begin
					if (tx_start) begin
						state_q <= START;
						txd <= START_BIT;
						bussy <= 1'b1;
					end
				end
				START: begin
					if (bit_done) begin
						state_q <= DATA;
						bit_idx <= '0;
						txd <= shift_q[0];  // LSB goes out first
					end
				end
				DATA: begin
					if (bit_done) begin
						if (bit_idx == BIT_W'(DATA_BITS - 1)) begin
							state_q <= STOP;
							txd <= STOP_BIT;
						end else begin
							bit_idx <= bit_idx + 1'b1;
							txd <= shift_q[1];  // Next bit before the shift lands
						end
					end
				end
				STOP: begin
					if (bit_done) begin
						state_q <= IDLE;
						bussy <= 1'b0;
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == IDLE && tx_start) begin
			shift_q <= tx_byte;
		end else if (state_q == DATA && bit_done) begin
			shift_q <= shift_q >> 1;
		end
	end

endmodule

//--- sensor_noc_top.sv
module sensor_noc_top #(
	parameter int NUM_CORES = 8,
	parameter int CLKS_PER_BIT = 434
) (
	input  logic clk,
	input  logic rst_n,
	input  logic sample_trigger,
	input  logic [NUM_CORES-1:0] sample_enable,
	input  noc_pkg::sensor_bank_t sensor_values,
	output logic txd
);
	import noc_pkg::*;
	import uart_pkg::*;

	logic [NUM_CORES-1:0] capture;
	sensor_bank_t capture_value;
	logic [NUM_CORES-1:0] req;
	logic [NUM_CORES-1:0] taken;
	flit_t flits [NUM_CORES];
	logic [DATA_BITS-1:0] tx_byte;
	logic tx_start;
	logic bussy;

	sensor_sampler #(
		.NUM_CORES(NUM_CORES)
	) u_sampler (
		.clk(clk),
		.rst_n(rst_n),
		.sample_trigger(sample_trigger),
		.sample_enable(sample_enable),
		.sensor_values(sensor_values),
		.capture(capture),
		.capture_value(capture_value)
	);

	for (genvar i = 0; i < NUM_CORES; i++) begin : g_core
		sensor_ni #(
			.CORE_ADDR(core_addr_t'(i))
		) u_ni (
			.clk(clk),
			.rst_n(rst_n),
			.capture(capture[i]),
			.value(capture_value[i]),
			.req(req[i]),
			.flit(flits[i]),
			.taken(taken[i])
		);
	end

	flit_arbiter #(
		.NUM_CORES(NUM_CORES)
	) u_arbiter (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.flits(flits),
		.taken(taken),
		.tx_byte(tx_byte),
		.tx_start(tx_start),
		.bussy(bussy)
	);

	uart_tx #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_uart (
		.clk(clk),
		.rst_n(rst_n),
		.tx_byte(tx_byte),
		.tx_start(tx_start),
		.bussy(bussy),
		.txd(txd)
	);

endmodule

//--- tb_sensor_noc.sv
module tb_sensor_noc;
	timeunit 1ns;
	timeprecision 1ps;

	import noc_pkg::*;

	localparam int NUM_CORES = 8;
	localparam int CLKS_PER_BIT = 4;
	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 16;
	localparam int BITS_PER_FLIT = 20;
	localparam int LINE_GAP = 12;  // Long enough for a stray flit to show its start bit
	localparam int FINAL_IDLE = 200;

	logic clk = 1'b0;
	logic rst_n;
	logic sample_trigger;
	logic [NUM_CORES-1:0] sample_enable;
	sensor_bank_t sensor_values;
	logic txd;

	logic [NUM_CORES-1:0] mask_q [$];
	logic [8*NUM_CORES-1:0] values_q [$];
	int line_no_q [$];
	int cycle_limit = 0;
	int cycle_count = 0;

	// Reference state of the round-robin pointer and the per-core sequence numbers
	logic [3:0] seq_model [NUM_CORES];
	int last_served = NUM_CORES - 1;

	sensor_noc_top #(
		.NUM_CORES(NUM_CORES),
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_sensor_noc_top (
		.clk(clk),
		.rst_n(rst_n),
		.sample_trigger(sample_trigger),
		.sample_enable(sample_enable),
		.sensor_values(sensor_values),
		.txd(txd)
	);

	initial begin
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic load_stimulus();
		int fd;
		int code;
		int file_line;
		string text;
		logic [NUM_CORES-1:0] mask;
		logic [7:0] v [8];
		logic [8*NUM_CORES-1:0] packed_vals;
		file_line = 0;
		fd = $fopen("sensor_stimulus.txt", "r");
		if (fd == 0) stop_on_error("Could not open sensor_stimulus.txt for reading");
		while ($fgets(text, fd) != 0) begin
			file_line++;
			if (text.len() < 2 || text.substr(0, 0) == "#") continue;  // Comment or blank line
			code = $sscanf(text, "%h %h %h %h %h %h %h %h %h",
				mask, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]);
			if (code != 9) begin
				stop_on_error($sformatf("Stimulus line %0d does not hold a mask and eight values",
					file_line));
			end
			for (int c = 0; c < NUM_CORES; c++) begin
				packed_vals[c*8 +: 8] = v[c];
			end
			mask_q.push_back(mask);
			values_q.push_back(packed_vals);
			line_no_q.push_back(file_line);
		end
		$fclose(fd);
		if (mask_q.size() == 0) stop_on_error("The stimulus file holds no trigger lines");
	endtask

	task automatic wait_falling_edges(input int n);
		repeat (n) @(negedge clk);
	endtask

	// A start bit would pull the line low, so an idle line stays at 1
	task automatic check_line_idle(input int cycles, input string name);
		repeat (cycles) begin
			@(negedge clk);
			assert (txd === 1'b1) else
				stop_on_error($sformatf("Fail %s idle line expected 1 actual %b", name, txd));
		end
	endtask

	task automatic receive_byte(input string name, output logic [7:0] data);
		logic [7:0] bits;
		@(negedge clk);
		while (txd !== 1'b0) @(negedge clk);
		wait_falling_edges(CLKS_PER_BIT / 2);  // Middle of the start bit
		assert (txd === 1'b0) else
			stop_on_error($sformatf("Fail %s start bit expected 0 actual %b", name, txd));
		for (int i = 0; i < 8; i++) begin
			wait_falling_edges(CLKS_PER_BIT);
			bits[i] = txd;  // LSB arrives first
		end
		wait_falling_edges(CLKS_PER_BIT);
		assert (txd === 1'b1) else
			stop_on_error($sformatf("Fail %s stop bit expected 1 actual %b", name, txd));
		data = bits;
	endtask

	task automatic run_line(input int n);
		logic [NUM_CORES-1:0] mask;
		logic [8*NUM_CORES-1:0] vals;
		logic [15:0] expected [$];
		logic [15:0] actual;
		logic [7:0] high_byte;
		logic [7:0] low_byte;
		sensor_bank_t bank;
		string name;
		int start;
		int cand;
		mask = mask_q[n];
		vals = values_q[n];
		start = last_served;
		for (int step = 1; step <= NUM_CORES; step++) begin
			cand = (start + step) % NUM_CORES;
			if (mask[cand]) begin
				expected.push_back({4'(cand), seq_model[cand], vals[cand*8 +: 8]});
				seq_model[cand] = (seq_model[cand] == 4'd15) ? 4'd0 : seq_model[cand] + 4'd1;
				last_served = cand;
			end
		end
		bank = '0;
		for (int c = 0; c < NUM_CORES; c++) begin
			bank[c] = vals[c*8 +: 8];
		end
		@(posedge clk);
		sample_trigger <= 1'b1;
		sample_enable <= mask;
		sensor_values <= bank;
		@(posedge clk);
		sample_trigger <= 1'b0;
		foreach (expected[k]) begin
			name = $sformatf("line %0d flit %0d", line_no_q[n], k);
			receive_byte(name, high_byte);
			receive_byte(name, low_byte);
			actual = {high_byte, low_byte};
			assert (actual === expected[k]) else
				stop_on_error($sformatf("Fail %s expected %h actual %h", name, expected[k], actual));
		end
		check_line_idle(LINE_GAP, $sformatf("line %0d after last flit", line_no_q[n]));
	endtask

	// Watchdog sized from the number of trigger lines
	initial begin
		wait (cycle_limit > 0);
		forever begin
			@(posedge clk);
			cycle_count++;
			if (cycle_count >= cycle_limit) begin
				stop_on_error($sformatf("The run timed out after %0d clock cycles", cycle_count));
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		sample_trigger = 1'b0;
		sample_enable = '0;
		sensor_values = '0;
		for (int c = 0; c < NUM_CORES; c++) begin
			seq_model[c] = 4'd0;
		end
		load_stimulus();
		cycle_limit = mask_q.size() * NUM_CORES * BITS_PER_FLIT * CLKS_PER_BIT
			+ mask_q.size() * 40 + 100;
		check_line_idle(RESET_CYCLES, "reset");
		@(posedge clk);
		rst_n <= 1'b1;
		check_line_idle(8, "before first trigger");
		for (int n = 0; n < mask_q.size(); n++) begin
			run_line(n);
		end
		check_line_idle(FINAL_IDLE, "after last line");
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

//--- vlog.f
noc_pkg.sv
uart_pkg.sv
sensor_sampler.sv
sensor_ni.sv
flit_arbiter.sv
uart_tx.sv
sensor_noc_top.sv
tb_sensor_noc.sv

//--- sensor_stimulus.txt
# Columns: enable mask, then sensor values for cores 0 to 7, all in hex
# Each line is one trigger
08 11 22 33 a5 44 55 66 77
01 3c 10 20 30 40 50 60 70
ff 01 12 23 34 45 56 67 78
0c 9a 8b 7c 6d 5e 4f 30 21
29 f0 e1 d2 c3 b4 a5 96 87
18 00 ff 00 5a a5 0f f0 33
88 13 24 35 46 57 68 79 8a
0a 80 81 82 83 84 85 86 87
48 de ad be ef ca fe ba be
08 c1 c2 c3 c4 c5 c6 c7 c8
3c 2a 3b 4c 5d 6e 7f 90 a1
c8 55 aa 55 aa 55 aa 55 aa
09 7e 6d 5c 4b 3a 29 18 07
80 b0 b1 b2 b3 b4 b5 b6 b7
0b 0f 1e 2d 3c 4b 5a 69 78
98 fe dc ba 98 76 54 32 10
28 12 34 56 78 9a bc de f0
0e 99 88 77 66 55 44 33 22
7f a0 b1 c2 d3 e4 f5 06 17
ab 61 72 83 94 a5 b6 c7 d8
